/* Makefile */
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := cpu_tb
FILELIST  := cpu.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cpu.f */
hw/cpu_pkg.sv
hw/reg_file.sv
hw/alu.sv
hw/cpu_control.sv
hw/cpu.sv
verif/cpu_assert.sv
verif/cpu_tb.sv

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpu_pkg::instr_t    instr,
    input  wire cpu_pkg::operands_t operands,
    output cpu_pkg::alu_out_t       alu_out
);
    import cpu_pkg::*;

    logic [word_width:0]    wide_sum;
    logic [word_width:0]    wide_diff;
    logic [shift_width-1:0] shift_amount;
    word_t                  imm_ext;

    assign wide_sum     = {1'b0, operands.a} + {1'b0, operands.b};
    assign wide_diff    = {1'b0, operands.a} - {1'b0, operands.b};
    assign shift_amount = operands.b[shift_width-1:0];
    assign imm_ext      = {{(word_width-imm_width){1'b0}}, instr.imm};

    always_comb begin
        alu_out.result      = operands.dst_value;
        alu_out.flag        = operands.dst_flag;
        alu_out.write_reg   = 1'b1;
        alu_out.take_branch = 1'b0;
        // Branch and jump targets are absolute word addresses
        alu_out.target      = imm_ext;

        case (instr.opcode)
            op_add: begin
                alu_out.result = wide_sum[word_width-1:0];
                alu_out.flag   = wide_sum[word_width];
            end
            op_sub: begin
                // Top bit of the widened difference is the borrow
                alu_out.result = wide_diff[word_width-1:0];
                alu_out.flag   = wide_diff[word_width];
            end
            op_and: begin
                alu_out.result = operands.a & operands.b;
                alu_out.flag   = (alu_out.result == '0);
            end
            op_or: begin
                alu_out.result = operands.a | operands.b;
                alu_out.flag   = (alu_out.result == '0);
            end
            op_xor: begin
                alu_out.result = operands.a ^ operands.b;
                alu_out.flag   = (alu_out.result == '0);
            end
            op_shl: begin
                alu_out.result = operands.a << shift_amount;
                alu_out.flag   = (alu_out.result == '0);
            end
            op_shr: begin
                alu_out.result = operands.a >> shift_amount;
                alu_out.flag   = (alu_out.result == '0);
            end
            op_lil: begin
                alu_out.result = imm_ext;
                alu_out.flag   = 1'b0;
            end
            op_lih: begin
                alu_out.result = {instr.imm, operands.dst_value[imm_width-1:0]};
                alu_out.flag   = 1'b0;
            end
            // Compares rewrite the destination with its own value
            op_cmpeq: alu_out.flag = (operands.a == operands.b);
            op_cmplt: alu_out.flag = (operands.a < operands.b);
            op_brf: begin
                alu_out.write_reg   = 1'b0;
                alu_out.take_branch = operands.flag_a;
            end
            op_jmp: begin
                alu_out.write_reg   = 1'b0;
                alu_out.take_branch = 1'b1;
            end
            op_load: begin
                // The sequencer replaces the result by the memory word
                alu_out.result = '0;
                alu_out.flag   = 1'b0;
            end
            default: alu_out.write_reg = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  wire                 clock,
    input  wire                 reset,
    input  wire cpu_pkg::word_t data,
    output cpu_pkg::word_t      data_out,
    output cpu_pkg::word_t      address,
    output logic                write,
    output logic                halted
);
    import cpu_pkg::*;

    instr_t     instr;
    operands_t  operands;
    alu_out_t   alu_out;
    logic       write_enable;
    reg_index_t write_index;
    word_t      write_value;
    logic       write_flag;

    cpu_control i_cpu_control (
        .clock        (clock),
        .reset        (reset),
        .data         (data),
        .operands     (operands),
        .alu_out      (alu_out),
        .instr        (instr),
        .write_enable (write_enable),
        .write_index  (write_index),
        .write_value  (write_value),
        .write_flag   (write_flag),
        .address      (address),
        .data_out     (data_out),
        .write        (write),
        .halted       (halted)
    );

    reg_file i_reg_file (
        .clock        (clock),
        .reset        (reset),
        .instr        (instr),
        .write_enable (write_enable),
        .write_index  (write_index),
        .write_value  (write_value),
        .write_flag   (write_flag),
        .operands     (operands)
    );

    // Result, flag and branch decision for the instruction in execute
    alu i_alu (
        .instr    (instr),
        .operands (operands),
        .alu_out  (alu_out)
    );

endmodule

`default_nettype wire

/* hw/cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
    input  wire                     clock,
    input  wire                     reset,
    input  wire cpu_pkg::word_t     data,
    input  wire cpu_pkg::operands_t operands,
    input  wire cpu_pkg::alu_out_t  alu_out,
    output cpu_pkg::instr_t         instr,
    output logic                    write_enable,
    output cpu_pkg::reg_index_t     write_index,
    output cpu_pkg::word_t          write_value,
    output logic                    write_flag,
    output cpu_pkg::word_t          address,
    output cpu_pkg::word_t          data_out,
    output logic                    write,
    output logic                    halted
);
    import cpu_pkg::*;

    state_t state;
    word_t  pc;
    word_t  next_pc;
    instr_t ir;
    logic   in_execute;
    logic   is_load;
    logic   is_store;
    logic   is_halt;

    assign in_execute = (state == st_execute);
    assign is_load    = (ir.opcode == op_load);
    assign is_store   = (ir.opcode == op_store);
    assign is_halt    = (ir.opcode == op_halt);

    // The program counter steps by one or takes the branch target
    assign next_pc = alu_out.take_branch ? alu_out.target : pc + 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_fetch;
            pc    <= reset_pc;
        end else begin
            case (state)
                st_fetch: state <= st_execute;
                st_execute: begin
                    pc    <= next_pc;
                    state <= is_halt ? st_halted : st_fetch;
                end
                default: state <= st_halted;
            endcase
        end
    end

    // The memory word on the port during fetch is the next instruction
    always_ff @(posedge clock) begin
        if (state == st_fetch) begin
            ir <= data;
        end
    end

    assign instr = ir;

    // Register write at the end of the execute cycle
    assign write_enable = in_execute && alu_out.write_reg;
    assign write_index  = ir.dst;
    assign write_value  = is_load ? data : alu_out.result;
    assign write_flag   = alu_out.flag;

    // Loads and stores borrow the port in execute with operand b as the word address
    assign address  = (in_execute && (is_load || is_store)) ? operands.b : pc;
    assign data_out = operands.a;
    assign write    = in_execute && is_store;
    assign halted   = (state == st_halted);

endmodule

`default_nettype wire

/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int word_width      = 32;
    localparam int reg_index_width = 3;
    localparam int imm_width       = 16;
    localparam int opcode_width    = 7;
    localparam int shift_width     = 5;
    localparam int num_regs        = 8;

    typedef logic [word_width-1:0]      word_t;
    typedef logic [reg_index_width-1:0] reg_index_t;
    typedef logic [imm_width-1:0]       imm_t;

    // Fetch starts from word zero after reset
    localparam word_t reset_pc = '0;

    // Code zero is left free so a cleared instruction word does nothing
    typedef enum logic [opcode_width-1:0] {
        op_add   = 7'd1,
        op_sub   = 7'd2,
        op_and   = 7'd3,
        op_or    = 7'd4,
        op_xor   = 7'd5,
        op_shl   = 7'd6,
        op_store = 7'd7,
        op_shr   = 7'd8,
        op_lil   = 7'd9,
        op_lih   = 7'd10,
        op_cmpeq = 7'd11,
        op_cmplt = 7'd12,
        op_brf   = 7'd13,
        op_jmp   = 7'd14,
        op_load  = 7'd15,
        op_halt  = 7'd127
    } opcode_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_halted
    } state_t;

    // Instruction word with the opcode in the low bits
    typedef struct packed {
        imm_t       imm;
        reg_index_t src_b;
        reg_index_t src_a;
        reg_index_t dst;
        opcode_t    opcode;
    } instr_t;

    // Register file reads for the instruction in execute
    typedef struct packed {
        word_t a;
        word_t b;
        word_t dst_value;
        logic  flag_a;
        logic  dst_flag;
    } operands_t;

    typedef struct packed {
        word_t result;
        logic  flag;
        logic  write_reg;
        logic  take_branch;
        word_t target;
    } alu_out_t;

endpackage

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                    clock,
    input  wire                    reset,
    input  wire cpu_pkg::instr_t   instr,
    input  wire                    write_enable,
    input  wire cpu_pkg::reg_index_t write_index,
    input  wire cpu_pkg::word_t    write_value,
    input  wire                    write_flag,
    output cpu_pkg::operands_t     operands
);
    import cpu_pkg::*;

    word_t regs  [num_regs];
    logic  flags [num_regs];

    // One write port that updates a value and its flag together
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i]  <= '0;
                flags[i] <= 1'b0;
            end
        end else if (write_enable) begin
            regs[write_index]  <= write_value;
            flags[write_index] <= write_flag;
        end
    end

    // Reads are combinational on the instruction fields
    always_comb begin
        operands.a         = regs[instr.src_a];
        operands.b         = regs[instr.src_b];
        operands.flag_a    = flags[instr.src_a];
        // lih and the compares need the old destination contents
        operands.dst_value = regs[instr.dst];
        operands.dst_flag  = flags[instr.dst];
    end

endmodule

`default_nettype wire

/* verif/cpu_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_assert (
    input wire                  clock,
    input wire                  reset,
    input wire cpu_pkg::state_t state,
    input wire                  write,
    input wire                  halted
);
    import cpu_pkg::*;

    int failure_count = 0;

    write_low_after_reset: assert property (@(posedge clock) reset |=> !write)
        else begin
            $error("write high in the cycle after reset");
            failure_count++;
        end

    // The port belongs to the instruction fetch here
    no_write_in_fetch: assert property (@(posedge clock) disable iff (reset)
        (state == st_fetch) |-> !write)
        else begin
            $error("write high during a fetch cycle");
            failure_count++;
        end

    halted_holds: assert property (@(posedge clock) disable iff (reset)
        halted |=> halted)
        else begin
            $error("halted dropped without a reset");
            failure_count++;
        end

    fetch_then_execute: assert property (@(posedge clock) disable iff (reset)
        (state == st_fetch) |=> (state == st_execute))
        else begin
            $error("fetch not followed by execute");
            failure_count++;
        end

    execute_then_fetch: assert property (@(posedge clock) disable iff (reset)
        (state == st_execute) |=> (state == st_fetch || state == st_halted))
        else begin
            $error("execute not followed by fetch or halt");
            failure_count++;
        end

endmodule

bind cpu_control cpu_assert i_cpu_assert (
    .clock  (clock),
    .reset  (reset),
    .state  (state),
    .write  (write),
    .halted (halted)
);

`default_nettype wire

/* verif/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    localparam int    mem_words  = 256;
    localparam int    timeout    = 5000;
    localparam int    num_groups = 7;
    localparam word_t loop_base  = 32'h80;
    localparam word_t store_base = 32'hc0;

    typedef struct packed {
        logic  store;
        logic  halt;
        word_t address;
        word_t store_data;
        word_t next_pc;
    } step_t;

    logic  clock = 1'b0;
    logic  reset = 1'b1;
    word_t data;
    word_t data_out;
    word_t address;
    logic  write;
    logic  halted;

    word_t image     [mem_words];
    word_t mem       [mem_words];
    word_t ref_mem   [mem_words];
    word_t ref_regs  [num_regs];
    logic  ref_flags [num_regs];
    word_t ref_pc;

    integer seed          = 95375;
    int     next_word     = 0;
    int     check_count   = 0;
    int     error_count   = 0;
    int     timeout_count = 0;
    logic   compare_done  = 1'b0;

    cpu i_cpu (
        .clock    (clock),
        .reset    (reset),
        .data     (data),
        .data_out (data_out),
        .address  (address),
        .write    (write),
        .halted   (halted)
    );

    always #50 clock = ~clock;

    // Memory answers with zero while the image is being loaded
    assign data = reset ? '0 : mem[address[7:0]];

    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= image[i];
            end
        end else if (write) begin
            mem[address[7:0]] <= data_out;
        end
    end

    function automatic word_t encode(opcode_t opcode, reg_index_t dst, reg_index_t src_a,
                                     reg_index_t src_b, imm_t imm);
        instr_t instr;
        instr.opcode = opcode;
        instr.dst    = dst;
        instr.src_a  = src_a;
        instr.src_b  = src_b;
        instr.imm    = imm;
        return instr;
    endfunction

    task automatic emit(word_t word);
        image[next_word] = word;
        next_word++;
    endtask

    // r2 holds one, r6 the store pointer and r7 is scratch
    function automatic reg_index_t choose_reg(word_t value);
        case (value % 32'd5)
            32'd0: return 3'd0;
            32'd1: return 3'd1;
            32'd2: return 3'd3;
            32'd3: return 3'd4;
            default: return 3'd5;
        endcase
    endfunction

    function automatic opcode_t draw_op(word_t value);
        case (value % 32'd9)
            32'd0: return op_add;
            32'd1: return op_sub;
            32'd2: return op_and;
            32'd3: return op_or;
            32'd4: return op_xor;
            32'd5: return op_shl;
            32'd6: return op_shr;
            32'd7: return op_cmpeq;
            default: return op_cmplt;
        endcase
    endfunction

    task automatic build_program();
        reg_index_t ra;
        reg_index_t rb;
        reg_index_t rd;
        opcode_t    op;
        word_t      a_value;
        word_t      b_value;
        for (int i = 0; i < mem_words; i++) begin
            image[i] = 32'hc0de_0000 | word_t'(i);
        end
        // Countdown from 5 that stores one word per pass from loop_base up
        emit(encode(op_lil, 3'd1, 3'd0, 3'd0, 16'd5));
        emit(encode(op_lil, 3'd2, 3'd0, 3'd0, 16'd1));
        emit(encode(op_lil, 3'd3, 3'd0, 3'd0, loop_base[15:0]));
        emit(encode(op_lil, 3'd6, 3'd0, 3'd0, store_base[15:0]));
        emit(encode(op_store, 3'd0, 3'd1, 3'd3, 16'd0));
        emit(encode(op_add, 3'd3, 3'd3, 3'd2, 16'd0));
        emit(encode(op_sub, 3'd1, 3'd1, 3'd2, 16'd0));
        emit(encode(op_cmpeq, 3'd5, 3'd1, 3'd4, 16'd0));
        emit(encode(op_brf, 3'd0, 3'd5, 3'd0, 16'd10));
        emit(encode(op_jmp, 3'd0, 3'd0, 3'd0, 16'd4));
        for (int g = 0; g < num_groups; g++) begin
            ra      = choose_reg($random(seed));
            rb      = choose_reg($random(seed));
            rd      = choose_reg($random(seed));
            op      = draw_op($random(seed));
            a_value = $random(seed);
            b_value = $random(seed);
            // Equal operands now and then so that cmpeq can come out true
            if (op == op_cmpeq && b_value[0]) begin
                b_value = a_value;
            end
            emit(encode(op_lil, ra, 3'd0, 3'd0, a_value[15:0]));
            emit(encode(op_lih, ra, 3'd0, 3'd0, a_value[31:16]));
            emit(encode(op_lil, rb, 3'd0, 3'd0, b_value[15:0]));
            emit(encode(op_lih, rb, 3'd0, 3'd0, b_value[31:16]));
            emit(encode(op, rd, ra, rb, 16'd0));
            emit(encode(op_store, 3'd0, rd, 3'd6, 16'd0));
            emit(encode(op_load, 3'd7, 3'd0, 3'd6, 16'd0));
            emit(encode(op_add, 3'd6, 3'd6, 3'd2, 16'd0));
            emit(encode(op_store, 3'd0, 3'd7, 3'd6, 16'd0));
            emit(encode(op_add, 3'd6, 3'd6, 3'd2, 16'd0));
            emit(encode(op_lil, 3'd7, 3'd0, 3'd0, 16'd0));
            // A set flag skips the marker load and leaves 0 in r7
            emit(encode(op_brf, 3'd0, rd, 3'd0, imm_t'(next_word + 2)));
            emit(encode(op_lil, 3'd7, 3'd0, 3'd0, 16'd1));
            emit(encode(op_store, 3'd0, 3'd7, 3'd6, 16'd0));
            emit(encode(op_add, 3'd6, 3'd6, 3'd2, 16'd0));
        end
        emit(encode(op_halt, 3'd0, 3'd0, 3'd0, 16'd0));
    endtask

    // One instruction on the reference state
    function automatic step_t execute_ref(instr_t instr);
        step_t step;
        word_t a;
        word_t b;
        word_t value;
        logic  flag;
        logic  write_reg;
        a            = ref_regs[instr.src_a];
        b            = ref_regs[instr.src_b];
        value        = ref_regs[instr.dst];
        flag         = ref_flags[instr.dst];
        write_reg    = 1'b1;
        step         = '0;
        step.address = ref_pc;
        step.next_pc = ref_pc + 32'd1;
        case (instr.opcode)
            op_add: begin
                value = a + b;
                // The sum wrapped exactly when there was a carry out
                flag  = (value < a);
            end
            op_sub: begin
                value = a - b;
                flag  = (a < b);
            end
            op_and: value = a & b;
            op_or:  value = a | b;
            op_xor: value = a ^ b;
            op_shl: value = a << b[4:0];
            op_shr: value = a >> b[4:0];
            op_lil: begin
                value = {16'h0000, instr.imm};
                flag  = 1'b0;
            end
            op_lih: begin
                value = {instr.imm, value[15:0]};
                flag  = 1'b0;
            end
            op_cmpeq: flag = (a == b);
            op_cmplt: flag = (a < b);
            op_brf: begin
                write_reg = 1'b0;
                if (ref_flags[instr.src_a]) begin
                    step.next_pc = {16'h0000, instr.imm};
                end
            end
            op_jmp: begin
                write_reg    = 1'b0;
                step.next_pc = {16'h0000, instr.imm};
            end
            op_load: begin
                value        = ref_mem[b[7:0]];
                flag         = 1'b0;
                step.address = b;
            end
            op_store: begin
                write_reg       = 1'b0;
                ref_mem[b[7:0]] = a;
                step.store      = 1'b1;
                step.address    = b;
                step.store_data = a;
            end
            op_halt: begin
                write_reg = 1'b0;
                step.halt = 1'b1;
            end
            default: write_reg = 1'b0;
        endcase
        if (instr.opcode inside {op_and, op_or, op_xor, op_shl, op_shr}) begin
            flag = (value == '0);
        end
        if (write_reg) begin
            ref_regs[instr.dst]  = value;
            ref_flags[instr.dst] = flag;
        end
        return step;
    endfunction

    task automatic check_word(string name, word_t expected, word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s expected %h, actual %h", name, expected, actual);
        end
    endtask

    initial begin : compare_process
        instr_t instr;
        step_t  step;
        int     cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (reset && cycles < timeout);
        if (reset) begin
            $display("Timeout: reset was never released");
            timeout_count++;
        end
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = image[i];
        end
        for (int i = 0; i < num_regs; i++) begin
            ref_regs[i]  = '0;
            ref_flags[i] = 1'b0;
        end
        ref_pc = '0;
        step   = '0;
        cycles = 0;
        // Each pass samples the fetch cycle and then the execute cycle
        while (!step.halt && cycles < timeout) begin
            check_word("address", ref_pc, address);
            check_bit("write", 1'b0, write);
            check_bit("halted", 1'b0, halted);
            instr = instr_t'(ref_mem[ref_pc[7:0]]);
            @(negedge clock);
            step = execute_ref(instr);
            check_word("address", step.address, address);
            check_bit("write", step.store, write);
            if (step.store) begin
                check_word("data_out", step.store_data, data_out);
            end
            ref_pc = step.next_pc;
            @(negedge clock);
            cycles += 2;
        end
        if (!step.halt) begin
            $display("Timeout: no halt instruction executed within %0d cycles", timeout);
            timeout_count++;
        end else begin
            cycles = 0;
            while (!halted && cycles < timeout) begin
                @(negedge clock);
                cycles++;
            end
            if (!halted) begin
                $display("Timeout: halted did not rise after the halt instruction");
                timeout_count++;
            end
            repeat (4) begin
                check_bit("halted", 1'b1, halted);
                check_bit("write", 1'b0, write);
                @(negedge clock);
            end
            for (int i = 0; i < mem_words; i++) begin
                check_word($sformatf("mem[%0d]", i), ref_mem[i], mem[i]);
            end
        end
        compare_done = 1'b1;
    end

    initial begin : run_process
        int cycles;
        int timeouts;
        int assert_failures;
        build_program();
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        cycles = 0;
        while (!compare_done && cycles < timeout + 100) begin
            @(posedge clock);
            cycles++;
        end
        if (!compare_done) begin
            $display("Timeout: the compare process did not finish");
        end
        timeouts        = timeout_count + (compare_done ? 0 : 1);
        assert_failures = i_cpu.i_cpu_control.i_cpu_assert.failure_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
                 check_count, error_count, assert_failures, timeouts);
        if (error_count == 0 && assert_failures == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
